// ==== src/sdram_pkg.sv ====
// ----------------------------------------------------------------------
// Shared definitions for the SDRAM controller
//   Address, data and command widths of the SDR part
//   Timings in clock cycles and the mode register word
//   User address, data, command and sequencer state types
// ----------------------------------------------------------------------
`default_nettype none

package sdram_pkg;

    // Part geometry
    localparam int col_width  = 9;
    localparam int row_width  = 13;
    localparam int bank_width = 2;
    localparam int data_width = 16;
    localparam int addr_width = col_width + row_width + bank_width;

    // Timings in clock cycles, init_wait cut down for simulation
    localparam int init_wait        = 20;
    localparam int t_rp             = 1;
    localparam int t_rc             = 5;
    localparam int t_mrd            = 2;
    localparam int t_dpl            = 2;
    localparam int cas_latency      = 2;
    localparam int refresh_interval = 100;

    typedef logic [col_width-1:0]  sdram_col_t;
    typedef logic [row_width-1:0]  sdram_row_t;
    typedef logic [bank_width-1:0] sdram_bank_t;
    typedef logic [data_width-1:0] sdram_data_t;

    // Column in the low bits, bank on top
    typedef struct packed {
        sdram_bank_t bank;
        sdram_row_t  row;
        sdram_col_t  col;
    } sdram_addr_t;

    // Burst length 1, sequential, CAS latency in bits 6 to 4
    localparam sdram_row_t mode_register_value = {6'b000000, 3'(cas_latency), 4'b0000};

    typedef enum logic [2:0] {
        cmd_nop,
        cmd_active,
        cmd_read,
        cmd_write,
        cmd_precharge_all,
        cmd_auto_refresh,
        cmd_mode_set
    } sdram_cmd_t;

    typedef enum logic [3:0] {
        state_init,
        state_pall,
        state_init_cbr_1,
        state_init_cbr_2,
        state_mrs,
        state_refresh_pall,
        state_refresh,
        state_idle,
        state_write,
        state_precharge_wait,
        state_read,
        state_precharge
    } sdram_state_t;

endpackage

`default_nettype wire

// ==== src/sdram_refresh_timer.sv ====
// ----------------------------------------------------------------------
// Auto refresh interval timer
//   Counts cycles since the last auto refresh command
//   Raises refresh_due once refresh_interval cycles have passed
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sdram_refresh_timer
    import sdram_pkg::*;
(
    input  logic       sdram_clock,
    input  logic       sdram_reset,
    input  sdram_cmd_t cmd,
    output logic       refresh_due
);

    logic [$clog2(refresh_interval + 1)-1:0] refresh_counter;

    // Saturates at the interval so due stays high until served
    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset) begin
            refresh_counter <= '0;
        end
        else if (cmd == cmd_auto_refresh) begin
            refresh_counter <= '0;
        end
        else if (!refresh_due) begin
            refresh_counter <= refresh_counter + 1'b1;
        end
    end

    assign refresh_due =
        (refresh_counter == $bits(refresh_counter)'(refresh_interval));

endmodule

`default_nettype wire

// ==== src/sdram_sequencer.sv ====
// ----------------------------------------------------------------------
// SDRAM controller state machine
//   Power-up sequence, refresh, write and read bursts
//   State, access and read counters
//   One command per cycle toward the command encoder
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sdram_sequencer
    import sdram_pkg::*;
(
    input  logic        sdram_clock,
    input  logic        sdram_reset,
    input  logic        write_request,
    input  logic        read_request,
    input  sdram_addr_t address,
    input  sdram_col_t  access_num,
    input  logic        refresh_due,
    output sdram_cmd_t  cmd,
    output sdram_bank_t cmd_bank,
    output sdram_row_t  cmd_row,
    output sdram_col_t  cmd_column,
    output logic        idle,
    output logic        write_flag,
    output logic        refresh_mode
);

    sdram_state_t state;
    sdram_state_t next_state;
    logic [15:0]  state_counter;
    sdram_col_t   access_counter;
    sdram_col_t   read_counter;
    logic         first_cycle;
    logic         request;

    // True in the last cycle of a state that lasts the given number of cycles
    function automatic logic timer_done(input logic [15:0] count, input int cycles);
        return count == 16'(cycles - 1);
    endfunction

    assign first_cycle = (state_counter == 16'd0);
    assign request     = write_request || read_request;

    always_comb begin
        next_state = state;
        case (state)
            state_init: begin
                if (timer_done(state_counter, init_wait))
                    next_state = state_pall;
            end
            state_pall: begin
                if (timer_done(state_counter, t_rp))
                    next_state = state_init_cbr_1;
            end
            state_init_cbr_1: begin
                if (timer_done(state_counter, t_rc))
                    next_state = state_init_cbr_2;
            end
            state_init_cbr_2: begin
                if (timer_done(state_counter, t_rc))
                    next_state = state_mrs;
            end
            state_mrs: begin
                if (timer_done(state_counter, t_mrd))
                    next_state = state_idle;
            end
            state_refresh_pall: begin
                if (timer_done(state_counter, t_rp))
                    next_state = state_refresh;
            end
            state_refresh: begin
                if (timer_done(state_counter, t_rc))
                    next_state = state_idle;
            end
            state_idle: begin
                // Write wins over read, refresh only when nothing waits
                if (write_request)
                    next_state = state_write;
                else if (read_request)
                    next_state = state_read;
                else if (refresh_due)
                    next_state = state_refresh_pall;
            end
            state_write: begin
                if (access_counter == access_num - 1'b1)
                    next_state = state_precharge_wait;
            end
            state_precharge_wait: begin
                if (timer_done(state_counter, t_dpl))
                    next_state = state_precharge;
            end
            state_read: begin
                if (read_counter == access_num)
                    next_state = state_precharge;
            end
            state_precharge: begin
                if (timer_done(state_counter, t_rp))
                    next_state = state_idle;
            end
            default: begin
                next_state = state_init;
            end
        endcase
    end

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset)
            state <= state_init;
        else
            state <= next_state;
    end

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset)
            state_counter <= 16'd0;
        else if (next_state != state)
            state_counter <= 16'd0;
        else
            state_counter <= state_counter + 16'd1;
    end

    // Column offset within the burst
    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset)
            access_counter <= '0;
        else if ((state == state_write) || (state == state_read))
            access_counter <= access_counter + 1'b1;
        else
            access_counter <= '0;
    end

    // Words back from the part, counted once the first has come through CAS latency
    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset)
            read_counter <= '0;
        else if (state != state_read)
            read_counter <= '0;
        else if ((state_counter > 16'(cas_latency)) && (read_counter != access_num))
            read_counter <= read_counter + 1'b1;
    end

    always_comb begin
        cmd        = cmd_nop;
        cmd_bank   = '0;
        cmd_row    = '0;
        cmd_column = '0;
        case (state)
            state_pall, state_refresh_pall, state_precharge: begin
                if (first_cycle)
                    cmd = cmd_precharge_all;
            end
            state_init_cbr_1, state_init_cbr_2, state_refresh: begin
                if (first_cycle)
                    cmd = cmd_auto_refresh;
            end
            state_mrs: begin
                if (first_cycle)
                    cmd = cmd_mode_set;
            end
            state_idle: begin
                // Open the row in the accepting cycle
                if (request) begin
                    cmd      = cmd_active;
                    cmd_bank = address.bank;
                    cmd_row  = address.row;
                end
            end
            state_write: begin
                cmd        = cmd_write;
                cmd_bank   = address.bank;
                cmd_column = address.col + access_counter;
            end
            state_read: begin
                if (state_counter < 16'(access_num)) begin
                    cmd        = cmd_read;
                    cmd_bank   = address.bank;
                    cmd_column = address.col + access_counter;
                end
            end
            default: begin
                cmd = cmd_nop;
            end
        endcase
    end

    assign idle         = (state == state_idle);
    assign write_flag   = (state == state_write);
    assign refresh_mode = (state == state_refresh_pall) || (state == state_refresh);

endmodule

`default_nettype wire

// ==== src/sdram_command_encoder.sv ====
// ----------------------------------------------------------------------
// SDRAM command encoder
//   Registers each command as cs, ras, cas and we pin levels
//   Places row, column, A10 or mode word on the address pins
//   Drives write data and the data bus direction
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sdram_command_encoder
    import sdram_pkg::*;
(
    input  logic        sdram_clock,
    input  logic        sdram_reset,
    input  sdram_cmd_t  cmd,
    input  sdram_bank_t cmd_bank,
    input  sdram_row_t  cmd_row,
    input  sdram_col_t  cmd_column,
    input  sdram_data_t data_in,
    output sdram_row_t  sdram_address,
    output sdram_bank_t sdram_ba,
    output logic        sdram_cke,
    output logic        sdram_cs,
    output logic        sdram_ras,
    output logic        sdram_cas,
    output logic        sdram_we,
    output sdram_data_t sdram_dq_out,
    output logic        sdram_dq_io
);

    logic [2:0]  pin_cmd;
    sdram_row_t  address_next;
    sdram_bank_t ba_next;

    // ras, cas, we per the SDRAM truth table, cs is low for all of them
    always_comb begin
        pin_cmd      = 3'b111;
        address_next = '0;
        ba_next      = '0;
        case (cmd)
            cmd_active: begin
                pin_cmd      = 3'b011;
                address_next = cmd_row;
                ba_next      = cmd_bank;
            end
            cmd_read: begin
                pin_cmd      = 3'b101;
                address_next = {{(row_width - col_width){1'b0}}, cmd_column};
                ba_next      = cmd_bank;
            end
            cmd_write: begin
                pin_cmd      = 3'b100;
                address_next = {{(row_width - col_width){1'b0}}, cmd_column};
                ba_next      = cmd_bank;
            end
            cmd_precharge_all: begin
                pin_cmd          = 3'b010;
                // A10 selects all banks
                address_next[10] = 1'b1;
            end
            cmd_auto_refresh: pin_cmd = 3'b001;
            cmd_mode_set: begin
                pin_cmd      = 3'b000;
                address_next = mode_register_value;
            end
            default: pin_cmd = 3'b111;
        endcase
    end

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset) begin
            sdram_address <= '0;
            sdram_ba      <= '0;
            sdram_cke     <= 1'b0;
            sdram_cs      <= 1'b1;
            sdram_ras     <= 1'b1;
            sdram_cas     <= 1'b1;
            sdram_we      <= 1'b1;
            sdram_dq_out  <= '0;
            sdram_dq_io   <= 1'b1;
        end
        else begin
            sdram_address <= address_next;
            sdram_ba      <= ba_next;
            sdram_cke     <= 1'b1;
            sdram_cs      <= 1'b0;
            {sdram_ras, sdram_cas, sdram_we} <= pin_cmd;
            sdram_dq_out  <= (cmd == cmd_write) ? data_in : '0;
            sdram_dq_io   <= (cmd != cmd_write);
        end
    end

endmodule

`default_nettype wire

// ==== src/sdram_read_capture.sv ====
// ----------------------------------------------------------------------
// Read data capture
//   Delay line marking each read through the CAS latency
//   Registers returning words onto data_out with read_valid
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sdram_read_capture
    import sdram_pkg::*;
(
    input  logic        sdram_clock,
    input  logic        sdram_reset,
    input  sdram_cmd_t  cmd,
    input  sdram_data_t sdram_dq_in,
    output sdram_data_t data_out,
    output logic        read_valid
);

    // One stage for the encoder register plus the CAS latency
    logic [cas_latency:0] read_marker;

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset) begin
            read_marker <= '0;
            read_valid  <= 1'b0;
        end
        else begin
            read_marker <= {read_marker[cas_latency-1:0], cmd == cmd_read};
            read_valid  <= read_marker[cas_latency];
        end
    end

    // Word on the bus while the marker leaves the line
    always_ff @(posedge sdram_clock) begin
        if (read_marker[cas_latency])
            data_out <= sdram_dq_in;
    end

endmodule

`default_nettype wire

// ==== src/sdram_controller.sv ====
// ----------------------------------------------------------------------
// SDRAM controller top level
//   Sequencer, refresh timer, command encoder and read capture
//   User request and status ports, SDRAM pins
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sdram_controller
    import sdram_pkg::*;
(
    input  logic        sdram_clock,
    input  logic        sdram_reset,

    // User side
    input  logic        write_request,
    input  logic        read_request,
    input  sdram_addr_t address,
    input  sdram_col_t  access_num,
    input  sdram_data_t data_in,
    output sdram_data_t data_out,
    output logic        read_valid,
    output logic        write_flag,
    output logic        refresh_mode,
    output logic        idle,

    // SDRAM pins
    output sdram_row_t  sdram_address,
    output logic        sdram_cke,
    output logic        sdram_cs,
    output logic        sdram_ras,
    output logic        sdram_cas,
    output logic        sdram_we,
    output sdram_bank_t sdram_ba,
    input  sdram_data_t sdram_dq_in,
    output sdram_data_t sdram_dq_out,
    output logic        sdram_dq_io
);

    sdram_cmd_t  cmd;
    sdram_bank_t cmd_bank;
    sdram_row_t  cmd_row;
    sdram_col_t  cmd_column;
    logic        refresh_due;

    sdram_sequencer u_sdram_sequencer (
        .sdram_clock   (sdram_clock),
        .sdram_reset   (sdram_reset),
        .write_request (write_request),
        .read_request  (read_request),
        .address       (address),
        .access_num    (access_num),
        .refresh_due   (refresh_due),
        .cmd           (cmd),
        .cmd_bank      (cmd_bank),
        .cmd_row       (cmd_row),
        .cmd_column    (cmd_column),
        .idle          (idle),
        .write_flag    (write_flag),
        .refresh_mode  (refresh_mode)
    );

    sdram_refresh_timer u_sdram_refresh_timer (
        .sdram_clock (sdram_clock),
        .sdram_reset (sdram_reset),
        .cmd         (cmd),
        .refresh_due (refresh_due)
    );

    sdram_command_encoder u_sdram_command_encoder (
        .sdram_clock   (sdram_clock),
        .sdram_reset   (sdram_reset),
        .cmd           (cmd),
        .cmd_bank      (cmd_bank),
        .cmd_row       (cmd_row),
        .cmd_column    (cmd_column),
        .data_in       (data_in),
        .sdram_address (sdram_address),
        .sdram_ba      (sdram_ba),
        .sdram_cke     (sdram_cke),
        .sdram_cs      (sdram_cs),
        .sdram_ras     (sdram_ras),
        .sdram_cas     (sdram_cas),
        .sdram_we      (sdram_we),
        .sdram_dq_out  (sdram_dq_out),
        .sdram_dq_io   (sdram_dq_io)
    );

    sdram_read_capture u_sdram_read_capture (
        .sdram_clock (sdram_clock),
        .sdram_reset (sdram_reset),
        .cmd         (cmd),
        .sdram_dq_in (sdram_dq_in),
        .data_out    (data_out),
        .read_valid  (read_valid)
    );

endmodule

`default_nettype wire

// ==== tests/sdram_model.sv ====
// ----------------------------------------------------------------------
// Behavioral SDR SDRAM for simulation
//   Decodes the command pins on each rising edge
//   Open row per bank, sparse memory keyed by bank, row, column
//   Read data returned after the CAS latency
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sdram_model
    import sdram_pkg::*;
(
    input  logic        sdram_clock,
    input  logic        sdram_cke,
    input  logic        sdram_cs,
    input  logic        sdram_ras,
    input  logic        sdram_cas,
    input  logic        sdram_we,
    input  sdram_bank_t sdram_ba,
    input  sdram_row_t  sdram_address,
    input  sdram_data_t sdram_dq_out,
    input  logic        sdram_dq_io,
    output sdram_data_t sdram_dq_in,
    output sdram_cmd_t  bus_cmd
);

    sdram_data_t memory [logic [addr_width-1:0]];
    sdram_row_t  open_row [1 << bank_width];
    sdram_data_t read_pipe [cas_latency-1];

    // Command truth table, cs high or cke low is a NOP
    always_comb begin
        bus_cmd = cmd_nop;
        if (sdram_cke && !sdram_cs) begin
            case ({sdram_ras, sdram_cas, sdram_we})
                3'b011:  bus_cmd = cmd_active;
                3'b101:  bus_cmd = cmd_read;
                3'b100:  bus_cmd = cmd_write;
                3'b010:  bus_cmd = cmd_precharge_all;
                3'b001:  bus_cmd = cmd_auto_refresh;
                3'b000:  bus_cmd = cmd_mode_set;
                default: bus_cmd = cmd_nop;
            endcase
        end
    end

    always @(posedge sdram_clock) begin : sample_pins
        logic [addr_width-1:0] key;
        sdram_data_t           word;
        key  = {sdram_ba, open_row[sdram_ba], sdram_address[col_width-1:0]};
        word = '0;
        case (bus_cmd)
            cmd_active: open_row[sdram_ba] = sdram_address;
            cmd_write: begin
                if (!sdram_dq_io)
                    memory[key] = sdram_dq_out;
            end
            cmd_read: begin
                // Unwritten cells read as zero
                if (memory.exists(key))
                    word = memory[key];
            end
            default: ;
        endcase
        // Word is on the bus before the edge cas_latency cycles later
        read_pipe[0] <= word;
        for (int i = 1; i < cas_latency - 1; i++)
            read_pipe[i] <= read_pipe[i-1];
        sdram_dq_in <= read_pipe[cas_latency-2];
    end

endmodule

`default_nettype wire

// ==== tests/sdram_controller_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for the SDRAM controller
//   Clock, reset, write and read bursts with random stimulus
//   Shadow memory with the expected_word reference
//   Pin monitor, read data compare and cycle timeout
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sdram_controller_tb
    import sdram_pkg::*;
();

    localparam int timeout_cycles = 4000;
    localparam int refresh_gap    = refresh_interval + 16;

    logic        sdram_clock;
    logic        sdram_reset;
    logic        write_request;
    logic        read_request;
    sdram_addr_t address;
    sdram_col_t  access_num;
    sdram_data_t data_in;
    sdram_data_t data_out;
    logic        read_valid;
    logic        write_flag;
    logic        refresh_mode;
    logic        idle;
    sdram_row_t  sdram_address;
    logic        sdram_cke;
    logic        sdram_cs;
    logic        sdram_ras;
    logic        sdram_cas;
    logic        sdram_we;
    sdram_bank_t sdram_ba;
    sdram_data_t sdram_dq_in;
    sdram_data_t sdram_dq_out;
    logic        sdram_dq_io;
    sdram_cmd_t  bus_cmd;

    sdram_data_t shadow [logic [addr_width-1:0]];
    sdram_cmd_t  init_sequence [4] =
        '{cmd_precharge_all, cmd_auto_refresh, cmd_auto_refresh, cmd_mode_set};

    int         cycle_count = 0;
    int         refresh_count = 0;
    int         last_refresh_cycle = 0;
    int         init_index = 0;
    logic       powered_up = 1'b0;
    logic       op_write = 1'b0;
    logic       op_open = 1'b0;
    logic       precharge_seen = 1'b0;
    logic       idle_prev = 1'b0;
    logic       refresh_prev = 1'b0;
    sdram_cmd_t last_cmd = cmd_nop;
    sdram_col_t pin_count = '0;
    sdram_col_t flag_count = '0;
    sdram_col_t read_count = '0;

    sdram_controller u_sdram_controller (
        .sdram_clock   (sdram_clock),
        .sdram_reset   (sdram_reset),
        .write_request (write_request),
        .read_request  (read_request),
        .address       (address),
        .access_num    (access_num),
        .data_in       (data_in),
        .data_out      (data_out),
        .read_valid    (read_valid),
        .write_flag    (write_flag),
        .refresh_mode  (refresh_mode),
        .idle          (idle),
        .sdram_address (sdram_address),
        .sdram_cke     (sdram_cke),
        .sdram_cs      (sdram_cs),
        .sdram_ras     (sdram_ras),
        .sdram_cas     (sdram_cas),
        .sdram_we      (sdram_we),
        .sdram_ba      (sdram_ba),
        .sdram_dq_in   (sdram_dq_in),
        .sdram_dq_out  (sdram_dq_out),
        .sdram_dq_io   (sdram_dq_io)
    );

    sdram_model u_sdram_model (
        .sdram_clock   (sdram_clock),
        .sdram_cke     (sdram_cke),
        .sdram_cs      (sdram_cs),
        .sdram_ras     (sdram_ras),
        .sdram_cas     (sdram_cas),
        .sdram_we      (sdram_we),
        .sdram_ba      (sdram_ba),
        .sdram_address (sdram_address),
        .sdram_dq_out  (sdram_dq_out),
        .sdram_dq_io   (sdram_dq_io),
        .sdram_dq_in   (sdram_dq_in),
        .bus_cmd       (bus_cmd)
    );

    initial begin
        sdram_clock = 1'b0;
        forever #2 sdram_clock = ~sdram_clock;
    end

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input sdram_data_t got, input sdram_data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_command(input string name, input sdram_cmd_t got,
                                 input sdram_cmd_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_row(input string name, input sdram_row_t got, input sdram_row_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bank(input string name, input sdram_bank_t got, input sdram_bank_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input sdram_col_t got, input sdram_col_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Last word written to a cell, zero if never written
    function automatic sdram_data_t expected_word(input sdram_bank_t bank, input sdram_row_t row,
                                                  input sdram_col_t col);
        logic [addr_width-1:0] key;
        key = {bank, row, col};
        if (shadow.exists(key))
            return shadow[key];
        return '0;
    endfunction

    // Top row bit set only for cells that are never written
    function automatic sdram_addr_t random_address(input logic unwritten);
        sdram_addr_t addr;
        addr.bank             = sdram_bank_t'($urandom);
        addr.row              = sdram_row_t'($urandom);
        addr.row[row_width-1] = unwritten;
        addr.col              = sdram_col_t'($urandom);
        return addr;
    endfunction

    task automatic wait_for_idle();
        do @(posedge sdram_clock); while (!idle);
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(0, 3)) @(posedge sdram_clock);
    endtask

    // Returns at the edge where the request is accepted
    task automatic start_op(input logic is_write, input sdram_addr_t addr, input sdram_col_t len);
        address       <= addr;
        access_num    <= len;
        op_write      <= is_write;
        read_count    <= '0;
        write_request <= is_write;
        read_request  <= !is_write;
        do @(posedge sdram_clock); while (!idle);
        write_request <= 1'b0;
        read_request  <= 1'b0;
    endtask

    task automatic write_burst(input sdram_addr_t addr, input sdram_col_t len);
        sdram_data_t word;
        sdram_col_t  col;
        start_op(1'b1, addr, len);
        for (int i = 0; i < len; i++) begin
            if (i > 0)
                @(posedge sdram_clock);
            word    = sdram_data_t'($urandom);
            col     = sdram_col_t'(addr.col + i);
            data_in <= word;
            shadow[{addr.bank, addr.row, col}] = word;
        end
        wait_for_idle();
    endtask

    task automatic read_burst(input sdram_addr_t addr, input sdram_col_t len);
        start_op(1'b0, addr, len);
        wait_for_idle();
    endtask

    always @(posedge sdram_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            stop_run();
        end
    end

    // Read data against the reference, in column order
    always @(posedge sdram_clock) begin
        if (!sdram_reset && read_valid) begin
            check_word("data_out", data_out,
                       expected_word(address.bank, address.row,
                                     sdram_col_t'(address.col + read_count)));
            read_count <= read_count + 1'b1;
        end
    end

    always @(posedge sdram_clock) begin
        if (!sdram_reset) begin
            if (bus_cmd != cmd_nop && !powered_up) begin
                if (init_index >= 4) begin
                    $display("Unexpected command %s before idle at %0t", bus_cmd.name(), $time);
                    stop_run();
                end
                check_command("power-up command", bus_cmd, init_sequence[init_index]);
                if (bus_cmd == cmd_mode_set)
                    check_row("sdram_address", sdram_address, mode_register_value);
                init_index = init_index + 1;
            end
            if (bus_cmd == cmd_precharge_all && !sdram_address[10]) begin
                $display("Precharge all at %0t without address bit 10", $time);
                stop_run();
            end
            if (bus_cmd == cmd_auto_refresh) begin
                if (powered_up) begin
                    check_command("command before auto refresh", last_cmd, cmd_precharge_all);
                    if (cycle_count - last_refresh_cycle > refresh_gap) begin
                        $display("Auto refresh gap of %0d cycles at %0t is too long",
                                 cycle_count - last_refresh_cycle, $time);
                        stop_run();
                    end
                end
                last_refresh_cycle = cycle_count;
            end
            if (powered_up) begin
                case (bus_cmd)
                    cmd_active: begin
                        check_bank("sdram_ba", sdram_ba, address.bank);
                        check_row("sdram_address", sdram_address, address.row);
                        op_open        = 1'b1;
                        precharge_seen = 1'b0;
                        pin_count      = '0;
                        flag_count     = '0;
                    end
                    cmd_write, cmd_read: begin
                        check_command("bus command", bus_cmd, op_write ? cmd_write : cmd_read);
                        check_bank("sdram_ba", sdram_ba, address.bank);
                        check_row("sdram_address", sdram_address,
                                  sdram_row_t'(sdram_col_t'(address.col + pin_count)));
                        if (op_write) begin
                            if (sdram_dq_io) begin
                                $display("Data bus not driven for write at %0t", $time);
                                stop_run();
                            end
                            check_word("sdram_dq_out", sdram_dq_out,
                                       expected_word(address.bank, address.row,
                                                     sdram_col_t'(address.col + pin_count)));
                        end
                        pin_count = pin_count + 1'b1;
                    end
                    cmd_precharge_all: precharge_seen = 1'b1;
                    default: ;
                endcase
            end
            if (write_flag)
                flag_count = flag_count + 1'b1;
            // End of an operation
            if (idle && !idle_prev && op_open) begin
                check_count("data commands", pin_count, access_num);
                if (op_write)
                    check_count("write_flag cycles", flag_count, access_num);
                else
                    check_count("read_valid words", read_count, access_num);
                if (!precharge_seen) begin
                    $display("Idle at %0t without a precharge after the burst", $time);
                    stop_run();
                end
                op_open = 1'b0;
            end
            if (idle && !powered_up) begin
                if (init_index != 4) begin
                    $display("Idle rose at %0t before the power-up sequence ended", $time);
                    stop_run();
                end
                powered_up = 1'b1;
            end
            if (refresh_mode && !refresh_prev)
                refresh_count <= refresh_count + 1;
            if (bus_cmd != cmd_nop)
                last_cmd = bus_cmd;
            idle_prev    = idle;
            refresh_prev = refresh_mode;
        end
    end

    initial begin
        sdram_addr_t addr;
        sdram_col_t  len;
        int          start_refreshes;
        sdram_reset   = 1'b1;
        write_request = 1'b0;
        read_request  = 1'b0;
        address       = '0;
        access_num    = '0;
        data_in       = '0;
        void'($urandom(32'hcdca951d));
        repeat (3) @(posedge sdram_clock);
        if (sdram_cke !== 1'b0 || sdram_cs !== 1'b1) begin
            $display("Pins not at reset levels: cke %b, cs %b", sdram_cke, sdram_cs);
            stop_run();
        end
        sdram_reset <= 1'b0;
        wait_for_idle();

        repeat (6) begin
            addr = random_address(1'b0);
            len  = sdram_col_t'($urandom_range(1, 8));
            write_burst(addr, len);
            idle_gap();
            read_burst(addr, len);
            idle_gap();
        end

        repeat (2) begin
            read_burst(random_address(1'b1), sdram_col_t'($urandom_range(1, 8)));
            idle_gap();
        end

        // No requests, refresh runs by itself
        start_refreshes = refresh_count;
        repeat (3 * refresh_interval) @(posedge sdram_clock);
        if (refresh_count - start_refreshes < 2) begin
            $display("Only %0d refreshes while idle", refresh_count - start_refreshes);
            stop_run();
        end

        // Request raised in the middle of a refresh
        do @(posedge sdram_clock); while (!refresh_mode);
        addr = random_address(1'b0);
        len  = sdram_col_t'($urandom_range(1, 8));
        write_burst(addr, len);
        read_burst(addr, len);

        repeat (4) @(posedge sdram_clock);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/sdram_pkg.sv
src/sdram_refresh_timer.sv
src/sdram_sequencer.sv
src/sdram_command_encoder.sv
src/sdram_read_capture.sv
src/sdram_controller.sv
tests/sdram_model.sv
tests/sdram_controller_tb.sv
